//--- source/outputControl_settings.svh
`ifndef OUTPUTCONTROL_SETTINGS_SVH
`define OUTPUTCONTROL_SETTINGS_SVH

// channel counts
`define TRANSDUCER_COUNT 8
`define TRIG_LED_COUNT 16

// field widths
`define PHASE_DELAY_WIDTH 16
`define LED_TIME_WIDTH 16
`define CHARGE_BYTE_WIDTH 8
`define CHARGE_TIME_COUNT 4
`define CHARGE_SELECT_WIDTH 2
`define COMMAND_WIDTH 9
`define MODE_WIDTH 2

// one-hot command bit positions within the command field
`define CMD_SET_TRIG_LEDS 0
`define CMD_FIRE 2
`define CMD_SET_AMP 3
`define CMD_RESET_INTERRUPT 6
`define CMD_TRIGGER_MASK 9'b000000111

`endif

//--- source/outputControlPkg.sv
`include "outputControl_settings.svh"

package outputControlPkg;

	typedef logic [`PHASE_DELAY_WIDTH-1:0] phaseDelay_t;	// delay in txCLK cycles
	typedef logic [`CHARGE_BYTE_WIDTH:0] chargeTime_t;	// byte with a 1 below it, always odd
	typedef logic [`CHARGE_BYTE_WIDTH-1:0] chargeByte_t;
	typedef logic [`LED_TIME_WIDTH-1:0] ledTime_t;
	typedef logic [`COMMAND_WIDTH-1:0] commandField_t;

	// only modePio does anything, the rest force outputs to rest
	typedef enum logic [`MODE_WIDTH-1:0] {
		modeIdle,
		modePio,
		modeRam,
		modeRamSubcall
	} controlMode_e;

	// per-channel sequencing, shared by pulsers and LED timers
	typedef enum logic [1:0] {
		stateWaiting,
		stateDelaying,
		statePulsing,
		stateDone
	} channelState_e;

	// control word, mode sits in the low bits
	typedef struct packed {
		logic [1:0] pad;
		logic [`CHARGE_SELECT_WIDTH-1:0] chargeSelect;
		logic spare;
		logic [`TRIG_LED_COUNT-1:0] ledEnable;
		commandField_t command;
		controlMode_e mode;
	} pioControlWord_s;

	typedef struct packed {
		ledTime_t delay;	// upper half
		ledTime_t duration;
	} ledTiming_s;

endpackage

//--- source/pioCommandDecoder.sv
`timescale 1ns/1ps
`include "outputControl_settings.svh"

module pioCommandDecoder (
	input logic txCLK,
	input logic reset,
	input outputControlPkg::pioControlWord_s controlWord,
	input outputControlPkg::chargeByte_t [`CHARGE_TIME_COUNT-1:0] chargeTimes,
	input logic isSolo,
	input logic [`TRANSDUCER_COUNT-1:0] fireComplete,
	input logic [`TRIG_LED_COUNT-1:0] ledComplete,
	output logic fireArmed,
	output logic ledArmed,
	output logic channelReset,
	output logic ledStop,
	output outputControlPkg::chargeTime_t chargeTime,
	output logic internalTrigger,
	output logic commandDone
);

	outputControlPkg::commandField_t prevCommand;
	logic fireSeen;	// fire-type command since last reset-interrupt
	logic pioMode;
	logic commandChanged;
	logic allFireComplete;
	logic allLedComplete;

	assign pioMode = (controlWord.mode == outputControlPkg::modePio);
	assign allFireComplete = &fireComplete;
	assign allLedComplete = &ledComplete;

	// commands act once, on the edge where the field changes
	assign commandChanged = pioMode && (controlWord.command != '0)
		&& (controlWord.command != prevCommand);

	always_ff @(posedge txCLK)
	begin
		if (reset)
		begin
			prevCommand <= '0;
			fireArmed <= 1'b0;
			ledArmed <= 1'b0;
			channelReset <= 1'b1;
			ledStop <= 1'b1;
			chargeTime <= '0;
			internalTrigger <= 1'b0;
			commandDone <= 1'b0;
			fireSeen <= 1'b0;
		end
		else
		begin
			prevCommand <= controlWord.command;
			if (!pioMode)
			begin
				// abort everything, channels fall back to rest
				fireArmed <= 1'b0;
				ledArmed <= 1'b0;
				channelReset <= 1'b1;
				ledStop <= 1'b1;
				chargeTime <= '0;
				internalTrigger <= 1'b0;
				fireSeen <= 1'b0;
			end
			else
			begin
				ledStop <= 1'b0;

				if (fireArmed && allFireComplete)
				begin
					fireArmed <= 1'b0;
					channelReset <= 1'b1;
				end
				if (ledArmed && allLedComplete)
					ledArmed <= 1'b0;

				// done once nothing is pending after a fire-type command
				if (!fireArmed && !ledArmed && fireSeen)
					commandDone <= 1'b1;

				if (commandChanged)
				begin
					if ((controlWord.command & `CMD_TRIGGER_MASK) != '0)
					begin
						fireSeen <= 1'b1;
						if (isSolo)
							internalTrigger <= 1'b1;	// solo board triggers itself
					end
					if (controlWord.command[`CMD_FIRE])
					begin
						fireArmed <= 1'b1;
						channelReset <= 1'b0;
					end
					if (controlWord.command[`CMD_SET_TRIG_LEDS])
						ledArmed <= 1'b1;

					// charge time is frozen while a fire is pending
					if (controlWord.command[`CMD_SET_AMP] && !fireArmed)
						chargeTime <= {chargeTimes[controlWord.chargeSelect], 1'b1};

					if (controlWord.command[`CMD_RESET_INTERRUPT])
					begin
						internalTrigger <= 1'b0;
						commandDone <= 1'b0;	// overrides a set in this same cycle
						fireSeen <= 1'b0;
					end
				end
			end
		end
	end

endmodule

//--- source/transducerPulser.sv
`timescale 1ns/1ps

module transducerPulser (
	input logic txCLK,
	input logic reset,
	input logic channelReset,
	input logic isActive,
	input logic fireArmed,
	input logic trigger,
	input outputControlPkg::chargeTime_t chargeTime,
	input outputControlPkg::phaseDelay_t phaseDelay,
	output logic pulseOut,
	output logic fireComplete
);

	outputControlPkg::channelState_e state;
	outputControlPkg::phaseDelay_t count;	// used for delay, then for pulse width

	always_ff @(posedge txCLK)
	begin
		if (reset || channelReset || !fireArmed)
		begin
			state <= outputControlPkg::stateWaiting;
			count <= '0;
		end
		else
		begin
			case (state)
				outputControlPkg::stateWaiting:
				begin
					if (isActive && trigger)
					begin
						state <= outputControlPkg::stateDelaying;
						count <= phaseDelay;
					end
				end
				outputControlPkg::stateDelaying:
				begin
					if (count != '0)
						count <= count - 1'b1;
					else if (chargeTime == '0)
						state <= outputControlPkg::stateDone;	// no amplitude set yet
					else
					begin
						state <= outputControlPkg::statePulsing;
						count <= outputControlPkg::phaseDelay_t'(chargeTime) - 1'b1;
					end
				end
				outputControlPkg::statePulsing:
				begin
					if (count != '0)
						count <= count - 1'b1;
					else
						state <= outputControlPkg::stateDone;
				end
				default:
				begin
					state <= outputControlPkg::stateDone;	// hold until disarmed
				end
			endcase
		end
	end

	assign pulseOut = (state == outputControlPkg::statePulsing);
	assign fireComplete = !isActive || (state == outputControlPkg::stateDone);

endmodule

//--- source/triggerLedTimer.sv
`timescale 1ns/1ps

module triggerLedTimer (
	input logic txCLK,
	input logic reset,
	input logic ledStop,
	input logic restLevel,
	input logic isEnabled,
	input logic ledArmed,
	input logic trigger,
	input outputControlPkg::ledTiming_s timing,
	output logic ledOut,
	output logic ledComplete
);

	outputControlPkg::channelState_e state;
	outputControlPkg::ledTime_t count;
	logic inWindow;

	// ledStop is a hard abort, no waiting for the window to close
	always_ff @(posedge txCLK)
	begin
		if (reset || ledStop || !ledArmed)
		begin
			state <= outputControlPkg::stateWaiting;
			count <= '0;
		end
		else
		begin
			case (state)
				outputControlPkg::stateWaiting:
				begin
					if (isEnabled && trigger)
					begin
						state <= outputControlPkg::stateDelaying;
						count <= timing.delay;
					end
				end
				outputControlPkg::stateDelaying:
				begin
					if (count != '0)
						count <= count - 1'b1;
					else if (timing.duration == '0)
						state <= outputControlPkg::stateDone;	// empty window
					else
					begin
						state <= outputControlPkg::statePulsing;
						count <= timing.duration - 1'b1;
					end
				end
				outputControlPkg::statePulsing:
				begin
					if (count != '0)
						count <= count - 1'b1;
					else
						state <= outputControlPkg::stateDone;
				end
				default:
				begin
					state <= outputControlPkg::stateDone;
				end
			endcase
		end
	end

	assign inWindow = (state == outputControlPkg::statePulsing);

	// flip away from rest only inside the window
	assign ledOut = inWindow ? !restLevel : restLevel;
	assign ledComplete = !isEnabled || (state == outputControlPkg::stateDone);

endmodule

//--- source/outputControlTop.sv
`timescale 1ns/1ps
`include "outputControl_settings.svh"

module outputControlTop (
	input logic txCLK,
	input logic reset,
	input outputControlPkg::pioControlWord_s controlWord,
	input outputControlPkg::chargeByte_t [`CHARGE_TIME_COUNT-1:0] chargeTimes,
	input outputControlPkg::phaseDelay_t [`TRANSDUCER_COUNT-1:0] phaseDelays,
	input outputControlPkg::ledTiming_s [`TRIG_LED_COUNT-1:0] ledTimings,
	input logic [`TRIG_LED_COUNT-1:0] ledRestLevels,
	input logic [`TRANSDUCER_COUNT-1:0] transducerActive,
	input logic isSolo,
	input logic externalTrigger,
	output logic [`TRANSDUCER_COUNT-1:0] transducerOutput,
	output logic [`TRIG_LED_COUNT-1:0] triggerLedOutput,
	output logic commandDone
);

	logic fireArmed;
	logic ledArmed;
	logic channelReset;
	logic ledStop;
	logic internalTrigger;
	logic trigger;
	outputControlPkg::chargeTime_t chargeTime;
	logic [`TRANSDUCER_COUNT-1:0] fireComplete;
	logic [`TRIG_LED_COUNT-1:0] ledComplete;

	// either source starts every armed channel at once
	assign trigger = externalTrigger | internalTrigger;

	pioCommandDecoder decoder (
		.txCLK(txCLK),
		.reset(reset),
		.controlWord(controlWord),
		.chargeTimes(chargeTimes),
		.isSolo(isSolo),
		.fireComplete(fireComplete),
		.ledComplete(ledComplete),
		.fireArmed(fireArmed),
		.ledArmed(ledArmed),
		.channelReset(channelReset),
		.ledStop(ledStop),
		.chargeTime(chargeTime),
		.internalTrigger(internalTrigger),
		.commandDone(commandDone)
	);

	for (genvar i = 0; i < `TRANSDUCER_COUNT; i++)
	begin : genPulser
		transducerPulser pulser (
			.txCLK(txCLK),
			.reset(reset),
			.channelReset(channelReset),
			.isActive(transducerActive[i]),
			.fireArmed(fireArmed),
			.trigger(trigger),
			.chargeTime(chargeTime),
			.phaseDelay(phaseDelays[i]),
			.pulseOut(transducerOutput[i]),
			.fireComplete(fireComplete[i])
		);
	end

	// LED enables come straight from the control word
	for (genvar i = 0; i < `TRIG_LED_COUNT; i++)
	begin : genLedTimer
		triggerLedTimer ledTimer (
			.txCLK(txCLK),
			.reset(reset),
			.ledStop(ledStop),
			.restLevel(ledRestLevels[i]),
			.isEnabled(controlWord.ledEnable[i]),
			.ledArmed(ledArmed),
			.trigger(trigger),
			.timing(ledTimings[i]),
			.ledOut(triggerLedOutput[i]),
			.ledComplete(ledComplete[i])
		);
	end

endmodule

//--- verif/txClockGen.sv
`timescale 1ns/1ps

module txClockGen (
	output logic txCLK
);

	initial
	begin
		txCLK = 1'b0;
		forever
			#2 txCLK = !txCLK;	// 4 ns period
	end

endmodule

//--- verif/outputControlTb.sv
`timescale 1ns/1ps
`include "outputControl_settings.svh"

module outputControlTb;

	localparam int clockPeriod = 4;
	localparam int maxDelay = 31;
	localparam int maxLength = 72;	// abort run windows reach 1 + 40 + 31
	localparam int sequenceCount = 4;
	localparam int marginCycles = 100;
	localparam int recordLimit = maxDelay + maxLength + marginCycles;
	localparam int watchdogCycles = sequenceCount * recordLimit + marginCycles;
	localparam int channelCount = `TRANSDUCER_COUNT + `TRIG_LED_COUNT;

	logic txCLK;
	logic reset;
	outputControlPkg::pioControlWord_s controlWord;
	outputControlPkg::chargeByte_t [`CHARGE_TIME_COUNT-1:0] chargeTimes;
	outputControlPkg::phaseDelay_t [`TRANSDUCER_COUNT-1:0] phaseDelays;
	outputControlPkg::ledTiming_s [`TRIG_LED_COUNT-1:0] ledTimings;
	logic [`TRIG_LED_COUNT-1:0] ledRestLevels;
	logic [`TRANSDUCER_COUNT-1:0] transducerActive;
	logic isSolo;
	logic externalTrigger;
	logic [`TRANSDUCER_COUNT-1:0] transducerOutput;
	logic [`TRIG_LED_COUNT-1:0] triggerLedOutput;
	logic commandDone;

	// low indices are transducers and the rest LEDs
	int rises [channelCount];
	int starts [channelCount];
	int widths [channelCount];

	txClockGen clockGen (.txCLK(txCLK));

	outputControlTop DUT (
		.txCLK(txCLK),
		.reset(reset),
		.controlWord(controlWord),
		.chargeTimes(chargeTimes),
		.phaseDelays(phaseDelays),
		.ledTimings(ledTimings),
		.ledRestLevels(ledRestLevels),
		.transducerActive(transducerActive),
		.isSolo(isSolo),
		.externalTrigger(externalTrigger),
		.transducerOutput(transducerOutput),
		.triggerLedOutput(triggerLedOutput),
		.commandDone(commandDone)
	);

	task automatic reportError(input string message);
		$display("ERROR at %0d ns: %s", $time, message);
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic issueCommand(input int mask);
		@(posedge txCLK);
		controlWord.command <= outputControlPkg::commandField_t'(mask);
		@(posedge txCLK);	// decoder acts here
	endtask

	task automatic randomizeSettings(input int durationExtra);
		int unsigned draw;
		outputControlPkg::phaseDelay_t [`TRANSDUCER_COUNT-1:0] delays;
		outputControlPkg::chargeByte_t [`CHARGE_TIME_COUNT-1:0] bytes;
		outputControlPkg::ledTiming_s [`TRIG_LED_COUNT-1:0] timings;
		@(posedge txCLK);
		for (int i = 0; i < `TRANSDUCER_COUNT; i++)
			delays[i] = outputControlPkg::phaseDelay_t'($urandom % (maxDelay + 1));
		for (int i = 0; i < `CHARGE_TIME_COUNT; i++)
			bytes[i] = outputControlPkg::chargeByte_t'($urandom % 32);
		for (int i = 0; i < `TRIG_LED_COUNT; i++)
		begin
			timings[i].delay = outputControlPkg::ledTime_t'($urandom % (maxDelay + 1));
			timings[i].duration = outputControlPkg::ledTime_t'(1 + durationExtra + $urandom % 32);
		end
		draw = $urandom;
		phaseDelays <= delays;
		chargeTimes <= bytes;
		ledTimings <= timings;
		transducerActive <= draw[`TRANSDUCER_COUNT-1:0] | 1'b1;	// keep one channel busy
		controlWord.ledEnable <= draw[`TRANSDUCER_COUNT +: `TRIG_LED_COUNT] | 1'b1;
		controlWord.chargeSelect <= draw[31:30];
	endtask

	// logs every departure from rest until commandDone plus a hold time
	task automatic recordUntilDone(input int holdCycles);
		int cycle;
		int doneCycle;
		logic [channelCount-1:0] away;
		logic [channelCount-1:0] lastAway;
		cycle = 0;
		doneCycle = -1;
		lastAway = '0;
		for (int i = 0; i < channelCount; i++)
		begin
			rises[i] = 0;
			starts[i] = 0;
			widths[i] = 0;
		end
		while (cycle < recordLimit && (doneCycle < 0 || cycle < doneCycle + holdCycles))
		begin
			@(negedge txCLK);
			away = {triggerLedOutput ^ ledRestLevels, transducerOutput};
			for (int i = 0; i < channelCount; i++)
			begin
				if (away[i] && !lastAway[i])
				begin
					rises[i]++;
					starts[i] = cycle;
					widths[i] = 0;
				end
				widths[i] += away[i];
			end
			lastAway = away;
			if (commandDone && doneCycle < 0)
			begin
				doneCycle = cycle;
				assert (away == '0)
					else reportError("commandDone rose while a channel was still away from rest");
			end
			cycle++;
		end
		assert (doneCycle >= 0) else reportError("commandDone never rose after the command");
	endtask

	task automatic checkChannels(input logic ledRun, input int pulseLength);
		int refChannel;
		int refOffset;
		int startOffset;
		int windowLength;
		logic [channelCount-1:0] expected;
		refChannel = -1;
		refOffset = 0;
		expected = ledRun ? {controlWord.ledEnable, {`TRANSDUCER_COUNT{1'b0}}}
			: {{`TRIG_LED_COUNT{1'b0}}, transducerActive};
		for (int i = 0; i < channelCount; i++)
		begin
			if (i < `TRANSDUCER_COUNT)
			begin
				startOffset = phaseDelays[i];
				windowLength = pulseLength;
			end
			else
			begin
				startOffset = ledTimings[i - `TRANSDUCER_COUNT].delay;
				windowLength = ledTimings[i - `TRANSDUCER_COUNT].duration;
			end
			if (expected[i])
			begin
				if (refChannel < 0)
				begin
					refChannel = i;
					refOffset = startOffset;
				end
				assert (rises[i] == 1)
					else reportError($sformatf("channel %0d gave %0d windows", i, rises[i]));
				assert (widths[i] == windowLength) else reportError($sformatf(
					"channel %0d width %0d, expected %0d", i, widths[i], windowLength));
				assert (starts[i] - starts[refChannel] == startOffset - refOffset)
					else reportError($sformatf("channel %0d starts off its delay", i));
			end
			else
			begin
				assert (rises[i] == 0)
					else reportError($sformatf("idle channel %0d left its rest level", i));
			end
		end
	endtask

	task automatic runSequence(input logic ledRun, input logic solo);
		int pulseLength;
		randomizeSettings(0);
		isSolo <= solo;
		issueCommand(1 << `CMD_SET_AMP);
		pulseLength = 2 * chargeTimes[controlWord.chargeSelect] + 1;
		issueCommand(ledRun ? (1 << `CMD_SET_TRIG_LEDS) : (1 << `CMD_FIRE));
		if (!solo)
		begin
			repeat (20)
			begin
				@(negedge txCLK);
				assert (transducerOutput == '0)
					else reportError("transducer pulsed before the external trigger");
			end
			@(posedge txCLK);
			externalTrigger <= 1'b1;
		end
		recordUntilDone(30);	// command still held so a second pulse would show here
		checkChannels(ledRun, pulseLength);
		issueCommand(1 << `CMD_RESET_INTERRUPT);
		externalTrigger <= 1'b0;
		@(negedge txCLK);
		assert (!commandDone) else reportError("commandDone still high after reset-interrupt");
	endtask

	initial
	begin
		int unsigned draw;
		reset = 1'b1;
		controlWord = '0;
		chargeTimes = '0;
		phaseDelays = '0;
		ledTimings = '0;
		ledRestLevels = '0;
		transducerActive = '0;
		isSolo = 1'b0;
		externalTrigger = 1'b0;
		repeat (5) @(posedge txCLK);
		reset <= 1'b0;
		draw = $urandom(32'h684);
		ledRestLevels <= draw[`TRIG_LED_COUNT-1:0];
		@(negedge txCLK);
		assert (transducerOutput == '0 && triggerLedOutput == ledRestLevels && !commandDone)
			else reportError($sformatf("not at rest after reset, tx %h led %h",
				transducerOutput, triggerLedOutput));
		@(posedge txCLK);
		controlWord.mode <= outputControlPkg::modePio;
		runSequence(1'b0, 1'b1);
		runSequence(1'b1, 1'b1);
		runSequence(1'b0, 1'b0);
		// abort in the middle of an LED window
		randomizeSettings(40);
		isSolo <= 1'b1;
		issueCommand(1 << `CMD_SET_AMP);
		issueCommand((1 << `CMD_FIRE) | (1 << `CMD_SET_TRIG_LEDS));
		@(negedge txCLK);
		while ((triggerLedOutput ^ ledRestLevels) == '0)
			@(negedge txCLK);
		@(posedge txCLK);
		controlWord.mode <= outputControlPkg::modeIdle;
		repeat (2) @(posedge txCLK);
		@(negedge txCLK);
		assert (transducerOutput == '0 && triggerLedOutput == ledRestLevels)
			else reportError($sformatf("outputs not at rest after abort, tx %h led %h",
				transducerOutput, triggerLedOutput));
		repeat (20)
		begin
			@(negedge txCLK);
			assert (!commandDone) else reportError("commandDone rose after the abort");
		end
		$display("test passed");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("the run hung, no finish after %0d cycles", watchdogCycles);
		$display("test failed");
		$fatal(1, "watchdog timeout");
	end

endmodule

//--- list.f
+incdir+source
source/outputControlPkg.sv
source/pioCommandDecoder.sv
source/transducerPulser.sv
source/triggerLedTimer.sv
source/outputControlTop.sv
verif/txClockGen.sv
verif/outputControlTb.sv
